/* backingMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module backingMemory (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        memRead,
  input  logic                        memWrite,
  input  logic [`MEM_ADDR_WIDTH-1:0]  memAddr,
  input  logic [`WORD_WIDTH-1:0]      memWData,
  output logic [`WORD_WIDTH-1:0]      memRData,
  output logic                        memRValid
);

  localparam int MemWords = 1 << `MEM_ADDR_WIDTH;
  localparam int Latency  = `MEM_READ_LATENCY;

  logic [`WORD_WIDTH-1:0] mem [MemWords];
  logic [`WORD_WIDTH-1:0] dataPipe [Latency];
  logic [Latency-1:0]     validPipe;

  // storage starts out all zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < MemWords; i++) begin
        mem[i] <= '0;
      end
      validPipe <= '0;
    end else begin
      if (memWrite) begin
        mem[memAddr] <= memWData;
      end
      validPipe <= {validPipe[Latency-2:0], memRead};
    end
  end

  // read data sampled at request time, then delayed
  always_ff @(posedge clk) begin
    dataPipe[0] <= mem[memAddr];
    for (int i = 1; i < Latency; i++) begin
      dataPipe[i] <= dataPipe[i-1];
    end
  end

  assign memRData  = dataPipe[Latency-1];
  assign memRValid = validPipe[Latency-1];

endmodule

`default_nettype wire

/* cacheArray.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheArray (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic [`ADDR_WIDTH-1:0]   rdAddr,
  output logic [`WORD_WIDTH-1:0]   rdData,
  output logic                     rdValid,
  output logic                     rdDirty,
  output logic                     rdHit,
  output cachePkg::tagT            rdTag,

  input  logic [`ADDR_WIDTH-1:0]   rd2Addr,
  output logic [`WORD_WIDTH-1:0]   rd2Data,
  output logic                     rd2Valid,
  output logic                     rd2Dirty,
  output logic                     rd2Hit,
  output cachePkg::tagT            rd2Tag,

  input  logic                     write,
  input  cachePkg::indexT          wrIndex,
  input  cachePkg::offsetT         wrOff,
  input  cachePkg::tagT            wrTag,
  input  logic                     wrValid,
  input  logic                     wrDirty,
  input  logic [`WORD_WIDTH-1:0]   wrData
);
  import cachePkg::*;

  localparam int NumLines = 1 << `INDEX_WIDTH;

  logic [`WORD_WIDTH-1:0] lineData  [NumLines];
  logic [`WORD_WIDTH-1:0] lineData2 [NumLines];
  tagT                    lineTag   [NumLines];
  tagT                    lineTag2  [NumLines];
  logic [NumLines-1:0]    lineValid, lineDirty, lineHit;
  logic [NumLines-1:0]    lineValid2, lineDirty2, lineHit2;
  indexT                  rdIndex, rd2Index;

  assign rdIndex  = rdAddr[`LINE_OFFSET_WIDTH +: `INDEX_WIDTH];
  assign rd2Index = rd2Addr[`LINE_OFFSET_WIDTH +: `INDEX_WIDTH];

  for (genvar g = 0; g < NumLines; g++) begin : genLine
    cacheLine lineInst (
      .clk      (clk),
      .rst_n    (rst_n),
      .rdAddr   (rdAddr),
      .rdData   (lineData[g]),
      .rdValid  (lineValid[g]),
      .rdDirty  (lineDirty[g]),
      .rdHit    (lineHit[g]),
      .rdTag    (lineTag[g]),
      .rd2Addr  (rd2Addr),
      .rd2Data  (lineData2[g]),
      .rd2Valid (lineValid2[g]),
      .rd2Dirty (lineDirty2[g]),
      .rd2Hit   (lineHit2[g]),
      .rd2Tag   (lineTag2[g]),
      // only the indexed line sees the write strobe
      .write    (write && (wrIndex == indexT'(g))),
      .wrOff    (wrOff),
      .wrTag    (wrTag),
      .wrValid  (wrValid),
      .wrDirty  (wrDirty),
      .wrData   (wrData)
    );
  end

  assign rdData   = lineData[rdIndex];
  assign rdValid  = lineValid[rdIndex];
  assign rdDirty  = lineDirty[rdIndex];
  assign rdHit    = lineHit[rdIndex];
  assign rdTag    = lineTag[rdIndex];

  assign rd2Data  = lineData2[rd2Index];
  assign rd2Valid = lineValid2[rd2Index];
  assign rd2Dirty = lineDirty2[rd2Index];
  assign rd2Hit   = lineHit2[rd2Index];
  assign rd2Tag   = lineTag2[rd2Index];

  // controller always writes whole words
  wordAlignedWrite: assert property (
    @(posedge clk) disable iff (!rst_n)
    write |-> (wrOff[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

/* cacheChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheChecker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    awvalid,
  input  logic                    awready,
  input  logic                    wvalid,
  input  logic                    wready,
  input  logic [1:0]              bresp,
  input  logic                    bvalid,
  input  logic                    bready,
  input  logic                    arvalid,
  input  logic                    arready,
  input  logic [`WORD_WIDTH-1:0]  rdata,
  input  logic [1:0]              rresp,
  input  logic                    rvalid,
  input  logic                    rready,
  input  logic [`WORD_WIDTH-1:0]  expRdata,
  input  logic [127:0]            testName,
  output int                      errorCount,
  output int                      checkCount
);

  logic                   readOpen;
  logic                   writeOpen;
  logic                   rStalled;
  logic                   bStalled;
  logic [`WORD_WIDTH-1:0] heldRdata;

  task automatic protocolError(input string what);
    $display("protocol error in %0s: %0s", testName, what);
    errorCount = errorCount + 1;
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      errorCount = 0;
      checkCount = 0;
      readOpen  <= 1'b0;
      writeOpen <= 1'b0;
      rStalled  <= 1'b0;
      bStalled  <= 1'b0;
      heldRdata <= '0;
    end else begin
      // one transaction at a time
      if ((arready || awready) && (rvalid || bvalid)) begin
        protocolError("address ready raised while a response was pending");
      end
      if (arvalid && arready) begin
        if (readOpen || writeOpen) begin
          protocolError("read address accepted while a transaction was open");
        end
        readOpen <= 1'b1;
      end
      if (awvalid && awready) begin
        if (!(wvalid && wready)) begin
          protocolError("write address accepted without its write data");
        end
        if (readOpen || writeOpen) begin
          protocolError("write accepted while a transaction was open");
        end
        writeOpen <= 1'b1;
      end
      if (rvalid && bvalid) begin
        protocolError("read and write responses valid together");
      end

      // held responses under back-pressure
      if (rStalled && !rvalid) begin
        protocolError("rvalid dropped before rready");
      end
      if (rStalled && rvalid && rdata !== heldRdata) begin
        protocolError("rdata changed while waiting for rready");
      end
      if (bStalled && !bvalid) begin
        protocolError("bvalid dropped before bready");
      end

      if (rvalid && rready) begin
        checkCount = checkCount + 1;
        if (!readOpen) begin
          protocolError("read response without a read request");
        end
        if (rdata !== expRdata) begin
          $display("FAIL %0s: rdata expected %h actual %h", testName, expRdata, rdata);
          errorCount = errorCount + 1;
        end
        if (rresp !== 2'b00) begin
          $display("FAIL %0s: rresp expected %0d actual %0d", testName, 2'b00, rresp);
          errorCount = errorCount + 1;
        end
        readOpen <= 1'b0;
      end
      if (bvalid && bready) begin
        checkCount = checkCount + 1;
        if (!writeOpen) begin
          protocolError("write response without a write request");
        end
        if (bresp !== 2'b00) begin
          $display("FAIL %0s: bresp expected %0d actual %0d", testName, 2'b00, bresp);
          errorCount = errorCount + 1;
        end
        writeOpen <= 1'b0;
      end

      rStalled  <= rvalid && !rready;
      bStalled  <= bvalid && !bready;
      heldRdata <= rdata;
    end
  end

endmodule

`default_nettype wire

/* cacheController.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheController (
  input  logic                        clk,
  input  logic                        rst_n,

  // AXI4-Lite slave
  input  logic [`ADDR_WIDTH-1:0]      awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`WORD_WIDTH-1:0]      wdata,
  input  logic [`STRB_WIDTH-1:0]      wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`ADDR_WIDTH-1:0]      araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`WORD_WIDTH-1:0]      rdata,
  output logic [1:0]                  rresp,
  output logic                        rvalid,
  input  logic                        rready,

  // cache array
  output logic [`ADDR_WIDTH-1:0]      rdAddr,
  input  logic [`WORD_WIDTH-1:0]      rdData,
  input  logic                        rdValid,
  input  logic                        rdDirty,
  input  logic                        rdHit,
  input  cachePkg::tagT               rdTag,
  output logic [`ADDR_WIDTH-1:0]      rd2Addr,
  input  logic [`WORD_WIDTH-1:0]      rd2Data,
  input  logic                        rd2Valid,
  input  logic                        rd2Dirty,
  input  logic                        rd2Hit,
  input  cachePkg::tagT               rd2Tag,
  output logic                        write,
  output cachePkg::indexT             wrIndex,
  output cachePkg::offsetT            wrOff,
  output cachePkg::tagT               wrTag,
  output logic                        wrValid,
  output logic                        wrDirty,
  output logic [`WORD_WIDTH-1:0]      wrData,

  // backing memory
  output logic                        memRead,
  output logic                        memWrite,
  output logic [`MEM_ADDR_WIDTH-1:0]  memAddr,
  output logic [`WORD_WIDTH-1:0]      memWData,
  input  logic [`WORD_WIDTH-1:0]      memRData,
  input  logic                        memRValid
);
  import cachePkg::*;

  localparam int WordBits = $clog2(`WORDS_PER_LINE);
  localparam logic [1:0] RespOkay = 2'b00;

  ctrlStateT state;
  logic isWrite;
  logic acceptRdy;
  logic readPending;
  logic [WordBits-1:0] wordCnt;
  logic lastWord;
  logic rdAccept, wrAccept, lookupHit;

  logic [`ADDR_WIDTH-1:0] reqAddr;
  logic [`WORD_WIDTH-1:0] reqData;
  logic [`STRB_WIDTH-1:0] reqStrb;
  logic [`WORD_WIDTH-1:0] mergedWord;
  tagT    reqTag, victimTag;
  indexT  reqIndex;
  offsetT reqOff;

  assign reqTag   = reqAddr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
  assign reqIndex = reqAddr[`LINE_OFFSET_WIDTH +: `INDEX_WIDTH];
  assign reqOff   = reqAddr[`LINE_OFFSET_WIDTH-1:0];
  assign lastWord = (wordCnt == WordBits'(`WORDS_PER_LINE - 1));

  // reads take priority over writes
  assign rdAccept = (state == Idle) && acceptRdy && arvalid;
  assign wrAccept = (state == Idle) && acceptRdy && !arvalid && awvalid && wvalid;
  assign arready  = acceptRdy;
  assign awready  = wrAccept;
  assign wready   = wrAccept;
  assign rresp    = RespOkay;
  assign bresp    = RespOkay;

  assign lookupHit = isWrite ? rd2Hit : rdHit;

  // port 2 scans the victim during write-back
  assign rdAddr  = reqAddr;
  assign rd2Addr = (state == WriteBack) ? {victimTag, reqIndex, wordCnt, 2'b00} : reqAddr;

  assign memRead  = (state == Refill) && !readPending;
  assign memWrite = (state == WriteBack);
  assign memAddr  = (state == WriteBack) ? {victimTag, reqIndex, wordCnt}
                                         : {reqTag, reqIndex, wordCnt};
  assign memWData = rd2Data;

  always_comb begin
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      mergedWord[8*b +: 8] = reqStrb[b] ? reqData[8*b +: 8] : rd2Data[8*b +: 8];
    end
  end

  always_comb begin
    write   = 1'b0;
    wrIndex = reqIndex;
    wrOff   = reqOff;
    wrTag   = reqTag;
    wrValid = 1'b1;
    wrDirty = 1'b1;
    wrData  = mergedWord;
    if (state == Lookup && isWrite && rd2Hit) begin
      write = 1'b1;
    end else if (state == Refill && memRValid) begin
      // line stays invalid until its last word lands
      write   = 1'b1;
      wrOff   = {wordCnt, 2'b00};
      wrValid = lastWord;
      wrDirty = 1'b0;
      wrData  = memRData;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= Idle;
      isWrite     <= 1'b0;
      acceptRdy   <= 1'b0;
      readPending <= 1'b0;
      wordCnt     <= '0;
      rvalid      <= 1'b0;
      bvalid      <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          acceptRdy <= !(rdAccept || wrAccept);
          if (rdAccept || wrAccept) begin
            isWrite <= wrAccept;
            state   <= Lookup;
          end
        end
        Lookup: begin
          wordCnt <= '0;
          if (lookupHit && isWrite) begin
            bvalid <= 1'b1;
            state  <= WriteResp;
          end else if (lookupHit) begin
            rvalid <= 1'b1;
            state  <= ReadResp;
          end else if (rd2Valid && rd2Dirty) begin
            state <= WriteBack;
          end else begin
            state <= Refill;
          end
        end
        WriteBack: begin
          wordCnt <= wordCnt + 1'b1;
          if (lastWord) begin
            state <= Refill;
          end
        end
        Refill: begin
          if (memRead) begin
            readPending <= 1'b1;
          end
          if (memRValid) begin
            readPending <= 1'b0;
            wordCnt     <= wordCnt + 1'b1;
            if (lastWord) begin
              state <= Lookup;
            end
          end
        end
        ReadResp: begin
          if (rready) begin
            rvalid    <= 1'b0;
            acceptRdy <= 1'b1;
            state     <= Idle;
          end
        end
        WriteResp: begin
          if (bready) begin
            bvalid    <= 1'b0;
            acceptRdy <= 1'b1;
            state     <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      reqAddr <= araddr;
    end else if (wrAccept) begin
      reqAddr <= awaddr;
      reqData <= wdata;
      reqStrb <= wstrb;
    end
    if (state == Lookup && !isWrite && rdHit) begin
      rdata <= rdData;
    end
    if (state == Lookup && !lookupHit) begin
      victimTag <= rd2Tag;
    end
  end

  rdataHeld: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && (state == ReadResp)
  );

  singleMemRead: assert property (
    @(posedge clk) disable iff (!rst_n)
    memRead |=> !memRead [*`MEM_READ_LATENCY]
  );

endmodule

`default_nettype wire

/* cacheLine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module cacheLine (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic [`ADDR_WIDTH-1:0]   rdAddr,
  output logic [`WORD_WIDTH-1:0]   rdData,
  output logic                     rdValid,
  output logic                     rdDirty,
  output logic                     rdHit,
  output cachePkg::tagT            rdTag,

  input  logic [`ADDR_WIDTH-1:0]   rd2Addr,
  output logic [`WORD_WIDTH-1:0]   rd2Data,
  output logic                     rd2Valid,
  output logic                     rd2Dirty,
  output logic                     rd2Hit,
  output cachePkg::tagT            rd2Tag,

  input  logic                     write,
  input  cachePkg::offsetT         wrOff,
  input  cachePkg::tagT            wrTag,
  input  logic                     wrValid,
  input  logic                     wrDirty,
  input  logic [`WORD_WIDTH-1:0]   wrData
);
  import cachePkg::*;

  logic [`WORD_WIDTH-1:0] words [`WORDS_PER_LINE];
  logic valid;
  logic dirty;
  tagT  storedTag;

  // port 1 lookup
  assign rdValid = valid;
  assign rdDirty = valid & dirty;
  assign rdTag   = storedTag;
  assign rdHit   = valid && (storedTag == rdAddr[`ADDR_WIDTH-1 -: `TAG_WIDTH]);
  assign rdData  = valid ? words[rdAddr[`LINE_OFFSET_WIDTH-1:2]] : '0;

  // port 2 lookup, same line
  assign rd2Valid = valid;
  assign rd2Dirty = valid & dirty;
  assign rd2Tag   = storedTag;
  assign rd2Hit   = valid && (storedTag == rd2Addr[`ADDR_WIDTH-1 -: `TAG_WIDTH]);
  assign rd2Data  = valid ? words[rd2Addr[`LINE_OFFSET_WIDTH-1:2]] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid     <= 1'b0;
      dirty     <= 1'b0;
      storedTag <= '0;
    end else if (write) begin
      valid     <= wrValid;
      dirty     <= wrDirty;
      storedTag <= wrTag;
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      words[wrOff[`LINE_OFFSET_WIDTH-1:2]] <= wrData;
    end
  end

  // a line only becomes valid through a valid write
  validOnlyByWrite: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(valid) |-> $past(write && wrValid)
  );

endmodule

`default_nettype wire

/* cachePkg.sv */
`default_nettype none

`include "cache_macros.svh"

package cachePkg;

  // fields of a byte address, msb to lsb
  typedef logic [`TAG_WIDTH-1:0] tagT;
  typedef logic [`INDEX_WIDTH-1:0] indexT;
  typedef logic [`LINE_OFFSET_WIDTH-1:0] offsetT;

  // controller FSM
  typedef enum logic [2:0] {
    Idle,
    Lookup,
    WriteBack,
    Refill,
    ReadResp,
    WriteResp
  } ctrlStateT;

endpackage

`default_nettype wire

/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// byte address into the 64 KB space
`define ADDR_WIDTH 16

// 64-byte lines of 16 words
`define LINE_OFFSET_WIDTH 6
`define WORDS_PER_LINE 16

// eight direct-mapped lines
`define INDEX_WIDTH 3

`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - `LINE_OFFSET_WIDTH)

`define WORD_WIDTH 32
`define STRB_WIDTH (`WORD_WIDTH / 8)

// backing store is word addressed
`define MEM_ADDR_WIDTH (`ADDR_WIDTH - 2)

// request to data, in cycles
`define MEM_READ_LATENCY 2

`endif

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f wbCache.f \
  --top-module tbWbCache \
  -o simWbCache

./obj_dir/simWbCache | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

/* tbWbCache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module tbWbCache;

  // resetRead 8, writeRead 16, partialWrite 16, conflictEvict 8, readyStall 20, randomMix 300
  localparam int NumOps     = 368;
  localparam int CycleLimit = NumOps * 80 + 1000;

  logic                    clk;
  logic                    rst_n;
  logic [`ADDR_WIDTH-1:0]  awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [`WORD_WIDTH-1:0]  wdata;
  logic [`STRB_WIDTH-1:0]  wstrb;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`ADDR_WIDTH-1:0]  araddr;
  logic                    arvalid;
  logic                    arready;
  logic [`WORD_WIDTH-1:0]  rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;

  logic [`WORD_WIDTH-1:0]  expRdata;
  logic [127:0]            testName;
  logic                    stallEn;
  int                      errorCount;
  int                      checkCount;
  int                      cycleCount;
  int                      seed = 32'h7326;

  // byte-wide image of what main memory should hold
  logic [7:0] shadow [1 << `ADDR_WIDTH];

  wbCache wbCache_inst (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  cacheChecker checkInst (
    .clk, .rst_n,
    .awvalid, .awready, .wvalid, .wready, .bresp, .bvalid, .bready,
    .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .expRdata, .testName, .errorCount, .checkCount
  );

  always #20 clk = ~clk;

  function automatic logic [`WORD_WIDTH-1:0] expectedRead(input logic [`ADDR_WIDTH-1:0] addr);
    logic [`ADDR_WIDTH-1:0] base;
    logic [`WORD_WIDTH-1:0] word;
    base = {addr[`ADDR_WIDTH-1:2], 2'b00};
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      word[8*b +: 8] = shadow[base + 16'(b)];
    end
    return word;
  endfunction

  function automatic void updateShadow(input logic [`ADDR_WIDTH-1:0] addr,
                                       input logic [`WORD_WIDTH-1:0] data,
                                       input logic [`STRB_WIDTH-1:0] strb);
    logic [`ADDR_WIDTH-1:0] base;
    base = {addr[`ADDR_WIDTH-1:2], 2'b00};
    for (int b = 0; b < `STRB_WIDTH; b++) begin
      if (strb[b]) begin
        shadow[base + 16'(b)] = data[8*b +: 8];
      end
    end
  endfunction

  // coin flip for ready when stalls are on
  function automatic logic drawReady();
    if (!stallEn) begin
      return 1'b1;
    end
    return 1'($random(seed));
  endfunction

  task automatic collectResponse(input logic isRead);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (isRead) begin
        rready <= drawReady();
      end else begin
        bready <= drawReady();
      end
      @(negedge clk);
      done = isRead ? (rvalid && rready) : (bvalid && bready);
    end
    @(posedge clk);
    rready <= 1'b0;
    bready <= 1'b0;
  endtask

  task automatic startWrite(input logic [`ADDR_WIDTH-1:0] addr,
                            input logic [`WORD_WIDTH-1:0] data,
                            input logic [`STRB_WIDTH-1:0] strb);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
  endtask

  task automatic finishWrite(input logic [`ADDR_WIDTH-1:0] addr,
                             input logic [`WORD_WIDTH-1:0] data,
                             input logic [`STRB_WIDTH-1:0] strb);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = awready && wready;
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    updateShadow(addr, data, strb);
  endtask

  task automatic startRead(input logic [`ADDR_WIDTH-1:0] addr);
    araddr   <= addr;
    arvalid  <= 1'b1;
    expRdata <= expectedRead(addr);
  endtask

  task automatic finishRead();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = arready;
    end
    @(posedge clk);
    arvalid <= 1'b0;
  endtask

  task automatic writeWord(input logic [`ADDR_WIDTH-1:0] addr,
                           input logic [`WORD_WIDTH-1:0] data,
                           input logic [`STRB_WIDTH-1:0] strb);
    @(posedge clk);
    startWrite(addr, data, strb);
    finishWrite(addr, data, strb);
    collectResponse(1'b0);
  endtask

  task automatic readWord(input logic [`ADDR_WIDTH-1:0] addr);
    @(posedge clk);
    startRead(addr);
    finishRead();
    collectResponse(1'b1);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("timeout: a response did not arrive within %0d cycles", CycleLimit);
      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`ADDR_WIDTH-1:0] addrA;
    logic [`ADDR_WIDTH-1:0] addrB;
    logic [`WORD_WIDTH-1:0] data;
    logic [`STRB_WIDTH-1:0] strb;
    clk        = 1'b0;
    rst_n      = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    expRdata   = '0;
    testName   = "reset";
    stallEn    = 1'b0;
    cycleCount = 0;
    for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
      shadow[a] = 8'h00;
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // one address per index before any write
    testName = "resetRead";
    for (int i = 0; i < 8; i++) begin
      readWord(16'h2000 + 16'(i * 68));
    end

    testName = "writeRead";
    for (int i = 0; i < 8; i++) begin
      writeWord(16'h0c00 + 16'(i * 72), $random(seed), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      readWord(16'h0c00 + 16'(i * 72));
    end

    // strobe patterns include the empty one
    testName = "partialWrite";
    for (int i = 0; i < 8; i++) begin
      writeWord(16'h0c00 + 16'(i * 72), $random(seed), 4'(3 * i + 1));
    end
    for (int i = 0; i < 8; i++) begin
      readWord(16'h0c00 + 16'(i * 72));
    end

    // same index 3 with tags 0x40 and 0x41
    testName = "conflictEvict";
    addrA = 16'h80c0;
    addrB = 16'h82c0;
    for (int i = 0; i < 3; i++) begin
      writeWord(addrA, $random(seed), 4'hf);
      writeWord(addrB, $random(seed), 4'hf);
    end
    readWord(addrA);
    readWord(addrB);

    // each request is raised while the previous response may still be stalled
    testName = "readyStall";
    stallEn = 1'b1;
    addr = 16'h1000 + 16'($random(seed) & 32'h3fc);
    data = $random(seed);
    strb = 4'($random(seed));
    @(posedge clk);
    startWrite(addr, data, strb);
    for (int i = 0; i < 10; i++) begin
      finishWrite(addr, data, strb);
      startRead(addr);
      collectResponse(1'b0);
      finishRead();
      if (i < 9) begin
        addr = 16'h1000 + 16'($random(seed) & 32'h3fc);
        data = $random(seed);
        strb = 4'($random(seed));
        startWrite(addr, data, strb);
      end
      collectResponse(1'b1);
    end

    // 1 KB window covers every index with two tags
    testName = "randomMix";
    for (int i = 0; i < 300; i++) begin
      addr = 16'h4000 + 16'($random(seed) & 32'h3fc);
      if (($random(seed) & 1) != 0) begin
        writeWord(addr, $random(seed), 4'($random(seed)));
      end else begin
        readWord(addr);
      end
    end

    repeat (4) @(posedge clk);
    if (checkCount != NumOps) begin
      $display("only %0d of %0d responses were checked", checkCount, NumOps);
    end
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0 && checkCount == NumOps) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wbCache.f */
+incdir+.
cachePkg.sv
cacheLine.sv
cacheArray.sv
backingMemory.sv
cacheController.sv
wbCache.sv
cacheChecker.sv
tbWbCache.sv

/* wbCache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_macros.svh"

module wbCache (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`ADDR_WIDTH-1:0]  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [`WORD_WIDTH-1:0]  wdata,
  input  logic [`STRB_WIDTH-1:0]  wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [`ADDR_WIDTH-1:0]  araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [`WORD_WIDTH-1:0]  rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready
);
  import cachePkg::*;

  logic [`ADDR_WIDTH-1:0]     rdAddr, rd2Addr;
  logic [`WORD_WIDTH-1:0]     rdData, rd2Data, wrData;
  logic                       rdValid, rdDirty, rdHit;
  logic                       rd2Valid, rd2Dirty, rd2Hit;
  tagT                        rdTag, rd2Tag, wrTag;
  logic                       write, wrValid, wrDirty;
  indexT                      wrIndex;
  offsetT                     wrOff;
  logic                       memRead, memWrite, memRValid;
  logic [`MEM_ADDR_WIDTH-1:0] memAddr;
  logic [`WORD_WIDTH-1:0]     memWData, memRData;

  cacheController ctrlInst (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .rdAddr, .rdData, .rdValid, .rdDirty, .rdHit, .rdTag,
    .rd2Addr, .rd2Data, .rd2Valid, .rd2Dirty, .rd2Hit, .rd2Tag,
    .write, .wrIndex, .wrOff, .wrTag, .wrValid, .wrDirty, .wrData,
    .memRead, .memWrite, .memAddr, .memWData, .memRData, .memRValid
  );

  cacheArray arrayInst (
    .clk, .rst_n,
    .rdAddr, .rdData, .rdValid, .rdDirty, .rdHit, .rdTag,
    .rd2Addr, .rd2Data, .rd2Valid, .rd2Dirty, .rd2Hit, .rd2Tag,
    .write, .wrIndex, .wrOff, .wrTag, .wrValid, .wrDirty, .wrData
  );

  backingMemory memInst (
    .clk, .rst_n,
    .memRead, .memWrite, .memAddr, .memWData, .memRData, .memRValid
  );

endmodule

`default_nettype wire
